// File: source/fp_add_stage.sv
`timescale 1ns/1ps

module fp_add_stage #(
    parameter int MANT_W = 24
) (
    input  logic              prod_valid,
    input  fp_mac_pkg::fp32_t prod,
    input  fp_mac_pkg::fp32_t acc,
    output logic              sum_valid,
    output fp_mac_pkg::fp32_t sum,
    output logic              sum_ovf
);

    localparam int EXT_W = MANT_W + fp_mac_pkg::GRS_W;      // mantissa plus g/r/s
    localparam int CNT_W = $clog2(EXT_W + 1);
    localparam int MAG_W = fp_mac_pkg::EXP_W + fp_mac_pkg::FRAC_W;

    logic                         p_inf;
    logic                         a_inf;
    logic [MANT_W-1:0]            p_man;
    logic [MANT_W-1:0]            a_man;
    logic                         p_big;
    fp_mac_pkg::fp32_t            big;
    fp_mac_pkg::fp32_t            sml;
    logic [MANT_W-1:0]            big_man;
    logic [MANT_W-1:0]            sml_man;
    logic [fp_mac_pkg::EXP_W-1:0] exp_diff;
    logic [2*MANT_W+1:0]          sml_wide;
    logic [EXT_W-1:0]             big_ext;
    logic [EXT_W-1:0]             sml_ext;
    logic                         eff_sub;
    logic [EXT_W:0]               raw_sum;
    logic [CNT_W-1:0]             lz_cnt;
    logic                         lz_zero;
    logic                         sum_zero;
    logic signed [9:0]            big_exp;
    logic [EXT_W-1:0]             norm_man;
    logic signed [9:0]            norm_exp;
    logic                         res_sign;
    fp_mac_pkg::fp32_t            rnd_word;
    logic                         rnd_ovf;

    assign p_inf = (prod.fields.exp == fp_mac_pkg::EXP_MAX);
    assign a_inf = (acc.fields.exp == fp_mac_pkg::EXP_MAX);

    // flushed operands carry no hidden one and no fraction
    assign p_man = (prod.fields.exp == '0) ? '0 : {1'b1, prod.fields.frac};
    assign a_man = (acc.fields.exp == '0) ? '0 : {1'b1, acc.fields.frac};

    // exp:frac compares as one unsigned magnitude
    assign p_big   = prod.raw[MAG_W-1:0] > acc.raw[MAG_W-1:0];
    assign big     = p_big ? prod : acc;
    assign sml     = p_big ? acc : prod;
    assign big_man = p_big ? p_man : a_man;
    assign sml_man = p_big ? a_man : p_man;

    assign exp_diff = big.fields.exp - sml.fields.exp;

    // shifted-out bits end up in the low half and fold into sticky
    assign sml_wide = {sml_man, {(MANT_W + 2){1'b0}}} >> exp_diff;
    assign sml_ext  = {sml_wide[2*MANT_W+1 -: MANT_W+2], |sml_wide[MANT_W-1:0]};
    assign big_ext  = {big_man, {fp_mac_pkg::GRS_W{1'b0}}};

    assign eff_sub = prod.fields.sign ^ acc.fields.sign;
    assign raw_sum = eff_sub ? ({1'b0, big_ext} - {1'b0, sml_ext})
                             : ({1'b0, big_ext} + {1'b0, sml_ext});

    lead_one_detect #(
        .WIDTH (EXT_W)
    ) u_lead_one_detect (
        .vec   (raw_sum[EXT_W-1:0]),
        .count (lz_cnt),
        .zero  (lz_zero)
    );

    assign sum_zero = lz_zero && !raw_sum[EXT_W];
    assign big_exp  = 10'(big.fields.exp);

    always_comb begin
        if (raw_sum[EXT_W]) begin
            // carry out, drop one bit into sticky
            norm_man = {raw_sum[EXT_W:2], raw_sum[1] | raw_sum[0]};
            norm_exp = big_exp + 10'sd1;
        end else if (sum_zero) begin
            norm_man = '0;
            norm_exp = '0;                           // round block packs a zero
        end else begin
            norm_man = raw_sum[EXT_W-1:0] << lz_cnt;
            norm_exp = big_exp - 10'(lz_cnt);
        end
    end

    // exact cancellation is +0, otherwise the larger magnitude wins
    assign res_sign = sum_zero ? 1'b0 : big.fields.sign;

    fp_round_pack u_fp_round_pack (
        .sign     (res_sign),
        .exp_in   (norm_exp),
        .mant_in  (norm_man),
        .result   (rnd_word),
        .overflow (rnd_ovf)
    );

    always_comb begin
        if (a_inf) begin
            sum = acc;                               // infinite acc absorbs all
        end else if (p_inf) begin
            sum = prod;
        end else begin
            sum = rnd_word;
        end
    end

    assign sum_ovf   = a_inf | p_inf | rnd_ovf;
    assign sum_valid = prod_valid;

    // no path through mul, round or inf muxing may build a NaN
    always_comb begin
        if (sum_valid) begin
            a_no_nan: assert final (!((sum.fields.exp == fp_mac_pkg::EXP_MAX) &&
                                      (sum.fields.frac != '0)))
                else $error("fp_add_stage: NaN on sum");
        end
    end

endmodule

// File: source/fp_mac_pkg.sv
package fp_mac_pkg;

    // IEEE-754 single precision field widths
    localparam int EXP_W    = 8;
    localparam int FRAC_W   = 23;
    localparam int MANT_W   = FRAC_W + 1;      // hidden one included

    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;             // all-ones exponent, inf here

    // guard, round and sticky bits below the mantissa LSB
    localparam int GRS_W    = 3;

    localparam logic [31:0] FP_ZERO = 32'h0000_0000;   // +0.0

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp32_fields_t;

    // same word seen as a plain vector or as the three fields
    typedef union packed {
        logic [31:0]  raw;
        fp32_fields_t fields;
    } fp32_t;

endpackage

// File: source/fp_mac_top.sv
`timescale 1ns/1ps

module fp_mac_top #(
    parameter int MANT_W = fp_mac_pkg::MANT_W
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              op_valid,
    input  fp_mac_pkg::fp32_t op_a,
    input  fp_mac_pkg::fp32_t op_b,
    input  logic              acc_clear,
    output fp_mac_pkg::fp32_t acc_out,
    output logic              done,
    output logic              ovf_flag
);

    logic              prod_valid;
    fp_mac_pkg::fp32_t prod;
    logic              sum_valid;
    fp_mac_pkg::fp32_t sum;
    logic              sum_ovf;

    // stage 1, multiply and round, registered
    fp_mul_stage #(
        .MANT_W (MANT_W)
    ) u_fp_mul_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (op_valid),
        .a          (op_a),
        .b          (op_b),
        .prod_valid (prod_valid),
        .prod       (prod)
    );

    // stage 2, add to accumulator, combinational
    fp_add_stage #(
        .MANT_W (MANT_W)
    ) u_fp_add_stage (
        .prod_valid (prod_valid),
        .prod       (prod),
        .acc        (acc_out),
        .sum_valid  (sum_valid),
        .sum        (sum),
        .sum_ovf    (sum_ovf)
    );

    mac_acc_regs u_mac_acc_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc_clear (acc_clear),
        .sum_valid (sum_valid),
        .sum       (sum),
        .sum_ovf   (sum_ovf),
        .acc       (acc_out),
        .done      (done),
        .ovf_flag  (ovf_flag)
    );

endmodule

// File: source/fp_mul_stage.sv
`timescale 1ns/1ps

module fp_mul_stage #(
    parameter int MANT_W = 24
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  fp_mac_pkg::fp32_t a,
    input  fp_mac_pkg::fp32_t b,
    output logic              prod_valid,
    output fp_mac_pkg::fp32_t prod
);

    localparam int EXT_W = MANT_W + fp_mac_pkg::GRS_W;

    logic                   zero_op;
    logic [MANT_W-1:0]      man_a;
    logic [MANT_W-1:0]      man_b;
    logic [2*MANT_W-1:0]    prod_m;
    logic [2*MANT_W-1:0]    norm_m;
    logic                   top_one;
    logic signed [9:0]      exp_raw;
    logic [EXT_W-1:0]       rnd_mant;
    logic signed [9:0]      rnd_exp;
    fp_mac_pkg::fp32_t      rnd_word;

    // exponent 0 is flushed, so either such operand forces a zero product
    assign zero_op = (a.fields.exp == '0) || (b.fields.exp == '0);

    assign man_a  = {1'b1, a.fields.frac};
    assign man_b  = {1'b1, b.fields.frac};
    assign prod_m = man_a * man_b;

    // 1.x * 1.y lands in [1, 4) so the leading one is one of the top two bits
    assign top_one = prod_m[2*MANT_W-1];
    assign norm_m  = top_one ? prod_m : (prod_m << 1);

    always_comb begin
        exp_raw = 10'(a.fields.exp) + 10'(b.fields.exp) - 10'(fp_mac_pkg::EXP_BIAS);
        if (top_one) begin
            exp_raw = exp_raw + 10'sd1;             // product was >= 2.0
        end
    end

    always_comb begin
        if (zero_op) begin
            rnd_mant = '0;
            rnd_exp  = '0;                          // packs as signed zero
        end else begin
            rnd_mant = {norm_m[2*MANT_W-1 -: MANT_W],
                        norm_m[MANT_W-1],           // guard
                        norm_m[MANT_W-2],           // round
                        |norm_m[MANT_W-3:0]};       // sticky
            rnd_exp  = exp_raw;
        end
    end

    fp_round_pack u_fp_round_pack (
        .sign     (a.fields.sign ^ b.fields.sign),
        .exp_in   (rnd_exp),
        .mant_in  (rnd_mant),
        .result   (rnd_word),
        .overflow ()                                // inf product flagged by the adder
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            prod <= rnd_word;
        end
    end

    // a product flushed to exponent 0 leaves no fraction behind
    a_flushed_prod: assert property (
        @(posedge clk) disable iff (!rst_n)
        prod_valid |-> ((prod.fields.exp != '0) || (prod.fields.frac == '0))
    ) else $error("fp_mul_stage: zero-exponent product with a fraction");

endmodule

// File: source/fp_round_pack.sv
`timescale 1ns/1ps

module fp_round_pack (
    input  logic                                            sign,
    input  logic signed [9:0]                               exp_in,
    input  logic [fp_mac_pkg::MANT_W+fp_mac_pkg::GRS_W-1:0] mant_in,
    output fp_mac_pkg::fp32_t                               result,
    output logic                                            overflow
);

    localparam int MW = fp_mac_pkg::MANT_W;
    localparam int GW = fp_mac_pkg::GRS_W;

    logic [MW-1:0]                 kept;
    logic                          guard;
    logic                          round_bit;
    logic                          sticky;
    logic                          round_up;
    logic [MW:0]                   rounded;
    logic                          carry;
    logic signed [9:0]             exp_adj;
    logic [fp_mac_pkg::FRAC_W-1:0] frac_out;

    assign kept      = mant_in[GW +: MW];
    assign guard     = mant_in[GW-1];
    assign round_bit = mant_in[GW-2];
    assign sticky    = mant_in[GW-3];

    // nearest even, a tie goes up only from an odd LSB
    assign round_up = guard & (round_bit | sticky | kept[0]);
    assign rounded  = {1'b0, kept} + (MW + 1)'(round_up);
    assign carry    = rounded[MW];                  // 1.111..1 rolled over to 10.0

    assign frac_out = carry ? rounded[MW-1:1] : rounded[MW-2:0];
    assign exp_adj  = carry ? (exp_in + 10'sd1) : exp_in;

    always_comb begin
        overflow           = 1'b0;
        result.fields.sign = sign;
        if (exp_adj >= fp_mac_pkg::EXP_MAX) begin
            result.fields.exp  = '1;                // signed infinity
            result.fields.frac = '0;
            overflow           = 1'b1;
        end else if (exp_adj <= 0) begin
            result.fields.exp  = '0;                // flush to signed zero
            result.fields.frac = '0;
        end else begin
            result.fields.exp  = exp_adj[fp_mac_pkg::EXP_W-1:0];
            result.fields.frac = frac_out;
        end
    end

endmodule

// File: source/lead_one_detect.sv
`timescale 1ns/1ps

module lead_one_detect #(
    parameter int WIDTH = 27
) (
    input  logic [WIDTH-1:0]           vec,
    output logic [$clog2(WIDTH+1)-1:0] count,
    output logic                       zero
);

    localparam int CW = $clog2(WIDTH + 1);

    // scan upward so the highest set bit has the last word
    always_comb begin
        count = CW'(WIDTH);                         // all zeros
        for (int i = 0; i < WIDTH; i++) begin
            if (vec[i]) begin
                count = CW'(WIDTH - 1 - i);
            end
        end
    end

    assign zero = ~|vec;

endmodule

// File: source/mac_acc_regs.sv
`timescale 1ns/1ps

module mac_acc_regs (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              acc_clear,
    input  logic              sum_valid,
    input  fp_mac_pkg::fp32_t sum,
    input  logic              sum_ovf,
    output fp_mac_pkg::fp32_t acc,
    output logic              done,
    output logic              ovf_flag
);

    // accumulator sits beside the adder and feeds it straight back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc.raw <= fp_mac_pkg::FP_ZERO;
        end else if (acc_clear) begin
            acc.raw <= fp_mac_pkg::FP_ZERO;         // clear beats a same-edge write
        end else if (sum_valid) begin
            acc <= sum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= sum_valid;                      // one pulse per operation
        end
    end

    // sticky until the next clear
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ovf_flag <= 1'b0;
        end else if (acc_clear) begin
            ovf_flag <= 1'b0;
        end else if (sum_valid && sum_ovf) begin
            ovf_flag <= 1'b1;
        end
    end

    // a set overflow flag always sits on an infinite accumulator
    a_ovf_on_inf: assert property (
        @(posedge clk) disable iff (!rst_n)
        ovf_flag |-> (acc.fields.exp == fp_mac_pkg::EXP_MAX)
    ) else $error("mac_acc_regs: overflow flag set on a finite accumulator");

endmodule

// File: src.f
+incdir+testbench
source/fp_mac_pkg.sv
source/lead_one_detect.sv
source/fp_round_pack.sv
source/fp_mul_stage.sv
source/fp_add_stage.sv
source/mac_acc_regs.sv
source/fp_mac_top.sv
testbench/tb_fp_mac.sv

// File: testbench/mac_vectors.svh
// columns: clear first, op_a, op_b, burst, expected acc_out, expected ovf_flag
// burst 1 issues on the cycle right after the previous operation
task automatic load_vectors();
    // exact accumulation, 1.5 * 2.0 three times
    add_vec(1'b1, 32'h3fc00000, 32'h40000000, 1'b0, 32'h40400000, 1'b0);
    add_vec(1'b0, 32'h3fc00000, 32'h40000000, 1'b0, 32'h40c00000, 1'b0);
    add_vec(1'b0, 32'h3fc00000, 32'h40000000, 1'b0, 32'h41100000, 1'b0);
    // product ties, even LSB stays, odd LSB rounds up
    add_vec(1'b1, 32'h3f800800, 32'h3f800800, 1'b0, 32'h3f801000, 1'b0);
    add_vec(1'b1, 32'h3f800800, 32'h3f801800, 1'b0, 32'h3f802002, 1'b0);
    // sum ties, 1 + 2^-24 and (1 + 2^-23) + 2^-24
    add_vec(1'b1, 32'h3f800000, 32'h3f800000, 1'b0, 32'h3f800000, 1'b0);
    add_vec(1'b0, 32'h39800000, 32'h39800000, 1'b0, 32'h3f800000, 1'b0);
    add_vec(1'b1, 32'h3f800001, 32'h3f800000, 1'b0, 32'h3f800001, 1'b0);
    add_vec(1'b0, 32'h39800000, 32'h39800000, 1'b0, 32'h3f800002, 1'b0);
    // cancellation down to 2^-22
    add_vec(1'b0, 32'hbf800000, 32'h3f800000, 1'b0, 32'h34800000, 1'b0);
    // equal and opposite, both orders give +0
    add_vec(1'b1, 32'h3fc00000, 32'h40000000, 1'b0, 32'h40400000, 1'b0);
    add_vec(1'b0, 32'hbfc00000, 32'h40000000, 1'b0, 32'h00000000, 1'b0);
    add_vec(1'b1, 32'hbfc00000, 32'h40000000, 1'b0, 32'hc0400000, 1'b0);
    add_vec(1'b0, 32'h3fc00000, 32'h40000000, 1'b0, 32'h00000000, 1'b0);
    // 2.0 - 1.5, exponents one apart
    add_vec(1'b1, 32'h40000000, 32'h3f800000, 1'b0, 32'h40000000, 1'b0);
    add_vec(1'b0, 32'hbfc00000, 32'h3f800000, 1'b0, 32'h3f000000, 1'b0);
    // zero, flushed subnormal and negative zero operands
    add_vec(1'b1, 32'h40000000, 32'h40400000, 1'b0, 32'h40c00000, 1'b0);
    add_vec(1'b0, 32'h00000000, 32'h41200000, 1'b0, 32'h40c00000, 1'b0);
    add_vec(1'b0, 32'h00400000, 32'h40000000, 1'b0, 32'h40c00000, 1'b0);
    add_vec(1'b0, 32'h80000000, 32'h3f800000, 1'b0, 32'h40c00000, 1'b0);
    // product overflow, then infinity holds
    add_vec(1'b1, 32'h7f000000, 32'h40000000, 1'b0, 32'h7f800000, 1'b1);
    add_vec(1'b0, 32'h3f800000, 32'h3f800000, 1'b0, 32'h7f800000, 1'b1);
    add_vec(1'b0, 32'hbf800000, 32'h7f000000, 1'b0, 32'h7f800000, 1'b1);
    add_vec(1'b1, 32'hff000000, 32'h40000000, 1'b0, 32'hff800000, 1'b1);
    // sum overflow, max + max
    add_vec(1'b1, 32'h7f7fffff, 32'h3f800000, 1'b0, 32'h7f7fffff, 1'b0);
    add_vec(1'b0, 32'h7f7fffff, 32'h3f800000, 1'b0, 32'h7f800000, 1'b1);
    // four operations with gaps
    add_vec(1'b1, 32'h3fc00000, 32'h40000000, 1'b0, 32'h40400000, 1'b0);
    add_vec(1'b0, 32'h3f000000, 32'h3f000000, 1'b0, 32'h40500000, 1'b0);
    add_vec(1'b0, 32'hbf800000, 32'h40400000, 1'b0, 32'h3e800000, 1'b0);
    add_vec(1'b0, 32'h3fc00000, 32'h3fc00000, 1'b0, 32'h40200000, 1'b0);
    // same four back to back
    add_vec(1'b1, 32'h3fc00000, 32'h40000000, 1'b0, 32'h40400000, 1'b0);
    add_vec(1'b0, 32'h3f000000, 32'h3f000000, 1'b1, 32'h40500000, 1'b0);
    add_vec(1'b0, 32'hbf800000, 32'h40400000, 1'b1, 32'h3e800000, 1'b0);
    add_vec(1'b0, 32'h3fc00000, 32'h3fc00000, 1'b1, 32'h40200000, 1'b0);
endtask

// File: testbench/tb_fp_mac.sv
`timescale 1ns/1ps

module tb_fp_mac;

    localparam int DONE_TIMEOUT = 50;               // cycles

    logic              clk;
    logic              rst_n;
    logic              op_valid;
    fp_mac_pkg::fp32_t op_a;
    fp_mac_pkg::fp32_t op_b;
    logic              acc_clear;
    fp_mac_pkg::fp32_t acc_out;
    logic              done;
    logic              ovf_flag;

    logic        vec_clear[$];
    logic [31:0] vec_a[$];
    logic [31:0] vec_b[$];
    logic        vec_burst[$];
    logic [31:0] vec_acc[$];
    logic        vec_ovf[$];

    int unsigned cycle_cnt;
    int unsigned issue_cycle[$];
    int          issued;
    int          checked;
    int          mismatch_errs;
    int          latency_errs;
    int          timeout_errs;
    int          stray_errs;
    logic        timed_out;

    fp_mac_top #(
        .MANT_W (fp_mac_pkg::MANT_W)
    ) u_fp_mac_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (op_valid),
        .op_a      (op_a),
        .op_b      (op_b),
        .acc_clear (acc_clear),
        .acc_out   (acc_out),
        .done      (done),
        .ovf_flag  (ovf_flag)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic add_vec(input logic clr, input logic [31:0] a, input logic [31:0] b,
                           input logic burst, input logic [31:0] exp_acc, input logic exp_ovf);
        vec_clear.push_back(clr);
        vec_a.push_back(a);
        vec_b.push_back(b);
        vec_burst.push_back(burst);
        vec_acc.push_back(exp_acc);
        vec_ovf.push_back(exp_ovf);
    endtask

    `include "mac_vectors.svh"

    // each done retires the oldest operation in flight
    always @(negedge clk) begin
        if (rst_n && done) begin
            if (checked >= issued) begin
                stray_errs++;
                $display("done went high at %0t with no operation in flight", $time);
            end else begin
                if (cycle_cnt - issue_cycle[checked] != 2) begin
                    latency_errs++;
                    $display("MISMATCH t=%0t op %0d done after %0d cycles, expected 2",
                             $time, checked, cycle_cnt - issue_cycle[checked]);
                end
                if (acc_out.raw !== vec_acc[checked] || ovf_flag !== vec_ovf[checked]) begin
                    mismatch_errs++;
                    $display("MISMATCH t=%0t op %0d acc_out %h ovf %b, expected %h ovf %b",
                             $time, checked, acc_out.raw, ovf_flag,
                             vec_acc[checked], vec_ovf[checked]);
                end
                checked++;
            end
        end
    end

    task automatic drive_op(input logic [31:0] a, input logic [31:0] b);
        @(negedge clk);
        op_valid = 1'b1;
        op_a.raw = a;
        op_b.raw = b;
        issue_cycle.push_back(cycle_cnt);
        issued++;
    endtask

    task automatic release_op();
        @(negedge clk);
        op_valid = 1'b0;
    endtask

    task automatic wait_all_done();
        int waited;
        waited = 0;
        while (checked < issued && waited < DONE_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (checked < issued) begin
            timeout_errs++;
            timed_out = 1'b1;
            $display("timeout at %0t, %0d of %0d operations got no done within %0d cycles",
                     $time, issued - checked, issued, DONE_TIMEOUT);
        end
    endtask

    task automatic clear_and_check();
        @(negedge clk);
        acc_clear = 1'b1;
        @(negedge clk);
        acc_clear = 1'b0;
        if (acc_out.raw !== 32'h0000_0000 || ovf_flag !== 1'b0) begin
            mismatch_errs++;
            $display("MISMATCH t=%0t after clear acc_out %h ovf %b, expected 00000000 ovf 0",
                     $time, acc_out.raw, ovf_flag);
        end
    endtask

    initial begin
        int gap;
        clk           = 1'b0;
        rst_n         = 1'b0;
        op_valid      = 1'b0;
        op_a.raw      = '0;
        op_b.raw      = '0;
        acc_clear     = 1'b0;
        cycle_cnt     = 0;
        issued        = 0;
        checked       = 0;
        mismatch_errs = 0;
        latency_errs  = 0;
        timeout_errs  = 0;
        stray_errs    = 0;
        timed_out     = 1'b0;
        void'($urandom(32'h6ac9));
        load_vectors();

        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        if (acc_out.raw !== 32'h0000_0000 || ovf_flag !== 1'b0 || done !== 1'b0) begin
            mismatch_errs++;
            $display("MISMATCH t=%0t after reset acc_out %h ovf %b done %b",
                     $time, acc_out.raw, ovf_flag, done);
        end

        for (int i = 0; i < vec_a.size() && !timed_out; i++) begin
            if (!vec_burst[i]) begin
                wait_all_done();
            end
            if (!timed_out) begin
                if (vec_clear[i]) begin
                    clear_and_check();
                end else if (!vec_burst[i]) begin
                    gap = $urandom % 4;             // 0 to 3 idle cycles
                    repeat (gap) @(negedge clk);
                end
                drive_op(vec_a[i], vec_b[i]);
                if (i + 1 == vec_a.size() || !vec_burst[i + 1]) begin
                    release_op();
                end
            end
        end
        if (!timed_out) begin
            wait_all_done();
        end

        $display("errors: mismatch %0d, latency %0d, timeout %0d, stray done %0d",
                 mismatch_errs, latency_errs, timeout_errs, stray_errs);
        if (mismatch_errs + latency_errs + timeout_errs + stray_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
